// File: hw/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    localparam int STAGE_CYCLES = 2;             // Clock cycles spent in each stage
    localparam int NUM_STAGES   = 5;             // Stages in the ring
    localparam int STAGE_W      = 3;
    localparam int CTRL_OP_W    = 2;
    localparam int CAUSE_W      = 3;

    // Phase value of the last cycle of a stage, where faults are sampled
    localparam logic PHASE_EVAL = 1'(STAGE_CYCLES - 1);

    typedef enum logic [STAGE_W-1:0] {
        stage_fetch   = 3'd0,
        stage_decode  = 3'd1,
        stage_execute = 3'd2,
        stage_memory  = 3'd3,
        stage_control = 3'd4                     // Last stage before wrap
    } stage_e;

    // Encoding follows the control stage decode of the datapath
    typedef enum logic [CTRL_OP_W-1:0] {
        ctrl_fault   = 2'b00,
        ctrl_ext_int = 2'b01,
        ctrl_sw_int  = 2'b10,
        ctrl_normal  = 2'b11
    } ctrl_op_e;

    // RISC-V exception codes folded into three bits
    // Code 3 is the breakpoint slot and serves as the idle value here
    typedef enum logic [CAUSE_W-1:0] {
        instr_addr_misaligned = 3'd0,
        instr_access_fault    = 3'd1,
        illegal_instr         = 3'd2,
        fault_none            = 3'd3,
        load_addr_misaligned  = 3'd4,
        load_access_fault     = 3'd5,
        store_addr_misaligned = 3'd6,
        store_access_fault    = 3'd7
    } fault_cause_e;

    // Fault report from the memory system
    typedef struct packed {
        logic valid;                             // Fault present this cycle
        logic is_store;                          // Store access in memory stage
        logic is_access;                         // Access fault, else misaligned
    } mem_fault_t;

    // Interrupt strobes, pending bits and take strobes share this shape
    typedef struct packed {
        logic ext;
        logic sw;
    } int_req_t;

    typedef struct packed {
        logic         valid;
        fault_cause_e cause;
    } fault_t;

    // Successor of a stage in ring order
    function automatic stage_e next_stage(stage_e cur);
        stage_e nxt;
        if (cur == stage_e'(NUM_STAGES - 1)) begin
            nxt = stage_fetch;                   // Wrap after control
        end else begin
            nxt = stage_e'(cur + 3'd1);
        end
        return nxt;
    endfunction

endpackage

// File: hw/fault_classifier.sv
`timescale 1ns/1ps

module fault_classifier (
    input  cpu_ctrl_pkg::mem_fault_t mem_fault,
    input  logic                     illegal_instr,
    input  cpu_ctrl_pkg::stage_e     stage,
    output cpu_ctrl_pkg::fault_t     fault
);

    import cpu_ctrl_pkg::*;

    logic illegal_hit;                           // Illegal instruction that counts
    logic fetch_mem_hit;                         // Memory fault during fetch
    logic data_mem_hit;                          // Memory fault during memory stage
    fault_cause_e fetch_cause;
    fault_cause_e load_cause;
    fault_cause_e store_cause;

    // The control stage never decodes and its illegal flag is stale
    assign illegal_hit   = illegal_instr && (stage != stage_control);
    assign fetch_mem_hit = mem_fault.valid && (stage == stage_fetch);
    assign data_mem_hit  = mem_fault.valid && (stage == stage_memory);

    always_comb begin
        if (mem_fault.is_access) begin
            fetch_cause = instr_access_fault;
            load_cause  = load_access_fault;
            store_cause = store_access_fault;
        end else begin
            fetch_cause = instr_addr_misaligned;
            load_cause  = load_addr_misaligned;
            store_cause = store_addr_misaligned;
        end
    end

    // Fixed priority with the illegal instruction first
    always_comb begin
        fault.valid = 1'b0;
        fault.cause = fault_none;
        if (illegal_hit) begin
            fault.valid = 1'b1;
            fault.cause = cpu_ctrl_pkg::illegal_instr;  // Port of the same name hides it
        end else if (fetch_mem_hit) begin
            fault.valid = 1'b1;
            fault.cause = fetch_cause;
        end else if (data_mem_hit) begin
            fault.valid = 1'b1;
            if (mem_fault.is_store) begin
                fault.cause = store_cause;
            end else begin
                fault.cause = load_cause;
            end
        end
    end

endmodule

// File: hw/interrupt_latch.sv
`timescale 1ns/1ps

module interrupt_latch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_ctrl_pkg::int_req_t int_req,
    input  cpu_ctrl_pkg::int_req_t take,
    output cpu_ctrl_pkg::int_req_t pending
);

    import cpu_ctrl_pkg::*;

    int_req_t pending_next;

    // Per-bit set/clear where the set wins over a take in the same cycle
    // A repeated strobe simply keeps the bit set
    always_comb begin
        pending_next.ext = int_req.ext | (pending.ext & ~take.ext);
        pending_next.sw  = int_req.sw  | (pending.sw  & ~take.sw);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;                       // Nothing pending after reset
        end else begin
            pending <= pending_next;
        end
    end

endmodule

// File: hw/stage_sequencer.sv
`timescale 1ns/1ps

module stage_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cpu_ctrl_pkg::fault_t       fault,
    input  cpu_ctrl_pkg::int_req_t     pending,
    output cpu_ctrl_pkg::stage_e       stage,
    output cpu_ctrl_pkg::ctrl_op_e     control_op,
    output cpu_ctrl_pkg::fault_cause_e fault_num,
    output logic                       trap,
    output cpu_ctrl_pkg::int_req_t     take
);

    import cpu_ctrl_pkg::*;

    logic     phase;                             // 0 first cycle, 1 evaluation cycle
    logic     eval;                              // Evaluation cycle of current stage
    logic     restart;                           // Fault seen in evaluation cycle
    logic     int_sample;                        // Memory stage ends without fault
    ctrl_op_e int_op;                            // Op chosen from pending interrupts
    int_req_t take_sel;                          // Interrupt that int_op consumes

    assign eval       = (phase == PHASE_EVAL);
    assign restart    = eval && fault.valid;
    assign int_sample = eval && !fault.valid && (stage == stage_memory);

    // External interrupt ranks above software interrupt
    always_comb begin
        int_op   = ctrl_normal;
        take_sel = '0;
        if (pending.ext) begin
            int_op       = ctrl_ext_int;
            take_sel.ext = 1'b1;
        end else if (pending.sw) begin
            int_op      = ctrl_sw_int;
            take_sel.sw = 1'b1;
        end
    end

    // Latch clears the taken bit on the same edge that loads control_op
    assign take = int_sample ? take_sel : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= 1'b0;
        end else if (eval) begin
            phase <= 1'b0;                       // New stage or restart at fetch
        end else begin
            phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage <= stage_fetch;
        end else if (restart) begin
            stage <= stage_fetch;                // Instruction abandoned
        end else if (eval) begin
            stage <= next_stage(stage);
        end
    end

    // Fault takes precedence over any interrupt choice
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            control_op <= ctrl_normal;
        end else if (restart) begin
            control_op <= ctrl_fault;
        end else if (int_sample) begin
            control_op <= int_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fault_num <= fault_none;
        end else if (restart) begin
            fault_num <= fault.cause;            // Held until the next fault
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trap <= 1'b0;
        end else begin
            trap <= restart;                     // One cycle, first fetch cycle
        end
    end

endmodule

// File: hw/cpu_ctrl_top.sv
`timescale 1ns/1ps

module cpu_ctrl_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cpu_ctrl_pkg::mem_fault_t   mem_fault,
    input  logic                       illegal_instr,
    input  cpu_ctrl_pkg::int_req_t     int_req,
    output cpu_ctrl_pkg::stage_e       stage,
    output cpu_ctrl_pkg::ctrl_op_e     control_op,
    output cpu_ctrl_pkg::fault_cause_e fault_num,
    output logic                       trap
);

    import cpu_ctrl_pkg::*;

    fault_t   fault;                             // Classified fault for this cycle
    int_req_t pending;                           // Latched interrupt requests
    int_req_t take;                              // Interrupt consumed by sequencer

    // Classifier looks at the stage the sequencer is in right now
    fault_classifier u_fault_classifier (
        .mem_fault     (mem_fault),
        .illegal_instr (illegal_instr),
        .stage         (stage),
        .fault         (fault)
    );

    interrupt_latch u_interrupt_latch (
        .clk     (clk),
        .rst_n   (rst_n),
        .int_req (int_req),
        .take    (take),
        .pending (pending)
    );

    stage_sequencer u_stage_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .fault      (fault),
        .pending    (pending),
        .stage      (stage),
        .control_op (control_op),
        .fault_num  (fault_num),
        .trap       (trap),
        .take       (take)
    );

endmodule

// File: verification/cpu_ctrl_asserts.sv
`timescale 1ns/1ps

module cpu_ctrl_asserts (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_ctrl_pkg::stage_e   stage,
    input  logic                   trap,
    input  cpu_ctrl_pkg::int_req_t take
);

    import cpu_ctrl_pkg::*;

    // Trap is a single-cycle pulse
    trap_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        trap |=> !trap
    ) else $error("trap high for two consecutive cycles");

    // Only one interrupt is consumed per memory stage
    take_one: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(take.ext && take.sw)
    ) else $error("take has both bits set");

    // A newly entered stage stays for its second cycle unless restarted
    stage_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stage != $past(stage)) |=> (trap || $stable(stage))
    ) else $error("stage held for only one cycle");

    trap_at_fetch: assert property (
        @(posedge clk) disable iff (!rst_n)
        trap |-> (stage == stage_fetch)
    ) else $error("trap raised outside fetch");

endmodule

// File: verification/cpu_ctrl_tb.sv
`timescale 1ns/1ps

module cpu_ctrl_tb;

    import cpu_ctrl_pkg::*;

    localparam int INSTR_CYCLES  = NUM_STAGES * STAGE_CYCLES;
    localparam int WAIT_LIMIT    = 3 * INSTR_CYCLES;   // Cycles allowed to reach a stage
    localparam int RANDOM_INSTRS = 30;

    logic         clk;
    logic         rst_n;
    mem_fault_t   mem_fault;
    logic         illegal_instr;
    int_req_t     int_req;
    stage_e       stage;
    ctrl_op_e     control_op;
    fault_cause_e fault_num;
    logic         trap;

    // Reference model state as of the last rising edge
    stage_e       m_stage;
    int           m_phase;
    int_req_t     m_pending;
    ctrl_op_e     m_ctrl;
    fault_cause_e m_cause;
    logic         m_trap;
    int           retired;                       // Instructions finished or abandoned
    integer       seed;

    cpu_ctrl_top u_cpu_ctrl_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_fault     (mem_fault),
        .illegal_instr (illegal_instr),
        .int_req       (int_req),
        .stage         (stage),
        .control_op    (control_op),
        .fault_num     (fault_num),
        .trap          (trap)
    );

    bind stage_sequencer cpu_ctrl_asserts u_cpu_ctrl_asserts (
        .clk   (clk),
        .rst_n (rst_n),
        .stage (stage),
        .trap  (trap),
        .take  (take)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;                       // 20 ns period

    function automatic stage_e ring_next(stage_e cur);
        case (cur)
            stage_fetch:   return stage_decode;
            stage_decode:  return stage_execute;
            stage_execute: return stage_memory;
            stage_memory:  return stage_control;
            default:       return stage_fetch;
        endcase
    endfunction

    // Illegal instruction first, then memory faults in fetch and memory only
    function automatic fault_t classify(mem_fault_t mf, logic ill, stage_e st);
        fault_t f;
        f.valid = 1'b0;
        f.cause = fault_none;
        if (ill && st != stage_control) begin
            f.valid = 1'b1;
            f.cause = cpu_ctrl_pkg::illegal_instr;
        end else if (mf.valid && st == stage_fetch) begin
            f.valid = 1'b1;
            if (mf.is_access) f.cause = instr_access_fault;
            else f.cause = instr_addr_misaligned;
        end else if (mf.valid && st == stage_memory) begin
            f.valid = 1'b1;
            case ({mf.is_store, mf.is_access})
                2'b00:   f.cause = load_addr_misaligned;
                2'b01:   f.cause = load_access_fault;
                2'b10:   f.cause = store_addr_misaligned;
                default: f.cause = store_access_fault;
            endcase
        end
        return f;
    endfunction

    function automatic mem_fault_t make_fault(logic is_store, logic is_access);
        mem_fault_t mf;
        mf.valid     = 1'b1;
        mf.is_store  = is_store;
        mf.is_access = is_access;
        return mf;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs();
        check_value("stage", 32'(stage), 32'(m_stage));
        check_value("control_op", 32'(control_op), 32'(m_ctrl));
        check_value("fault_num", 32'(fault_num), 32'(m_cause));
        check_value("trap", 32'(trap), 32'(m_trap));
    endtask

    // Advance the model across the next rising edge
    task automatic model_step(mem_fault_t mf, logic ill, int_req_t req);
        fault_t   f;
        logic     eval;
        int_req_t take;
        f      = classify(mf, ill, m_stage);
        eval   = (m_phase == STAGE_CYCLES - 1);
        take   = '0;
        m_trap = 1'b0;
        if (eval && f.valid) begin
            m_stage = stage_fetch;
            m_phase = 0;
            m_cause = f.cause;
            m_ctrl  = ctrl_fault;
            m_trap  = 1'b1;
            retired++;
        end else begin
            if (eval && m_stage == stage_memory) begin
                if (m_pending.ext) begin
                    m_ctrl   = ctrl_ext_int;
                    take.ext = 1'b1;
                end else if (m_pending.sw) begin
                    m_ctrl  = ctrl_sw_int;
                    take.sw = 1'b1;
                end else begin
                    m_ctrl = ctrl_normal;
                end
            end
            if (eval) begin
                if (m_stage == stage_control) retired++;
                m_stage = ring_next(m_stage);
                m_phase = 0;
            end else begin
                m_phase++;
            end
        end
        if (take.ext) m_pending.ext = 1'b0;
        if (take.sw) m_pending.sw = 1'b0;
        if (req.ext) m_pending.ext = 1'b1;       // New strobe beats a take
        if (req.sw) m_pending.sw = 1'b1;
    endtask

    task automatic sync_cycle();
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic apply_inputs(mem_fault_t mf, logic ill, int_req_t req);
        mem_fault     = mf;
        illegal_instr = ill;
        int_req       = req;
        model_step(mf, ill, req);
    endtask

    task automatic apply_idle();
        apply_inputs('0, 1'b0, '0);
    endtask

    // Returns at the falling edge of the wanted cycle before its inputs are driven
    task automatic wait_for(stage_e target, int ph);
        int   count;
        logic found;
        count = 0;
        found = 1'b0;
        while (!found) begin
            sync_cycle();
            if (stage == target && m_phase == ph) begin
                found = 1'b1;
            end else begin
                apply_idle();
                count++;
                if (count > WAIT_LIMIT) begin
                    $display("Timeout while waiting for stage %s, phase %0d", target.name(), ph);
                    $display("FAIL: see errors above");
                    $fatal(1);
                end
            end
        end
    endtask

    task automatic reset_dut();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n     = 1'b1;
        m_stage   = stage_fetch;
        m_phase   = 0;
        m_pending = '0;
        m_ctrl    = ctrl_normal;
        m_cause   = fault_none;
        m_trap    = 1'b0;
        compare_outputs();
    endtask

    task automatic test_reset();
        stage_e exp_st;
        reset_dut();
        check_value("stage", 32'(stage), 32'(stage_fetch));
        check_value("control_op", 32'(control_op), 32'(ctrl_normal));
        check_value("fault_num", 32'(fault_num), 32'(fault_none));
        check_value("trap", 32'(trap), 32'(1'b0));
        apply_idle();
        exp_st = stage_fetch;
        for (int i = 1; i <= 2 * INSTR_CYCLES; i++) begin
            sync_cycle();
            if (i % STAGE_CYCLES == 0) exp_st = ring_next(exp_st);
            check_value("stage", 32'(stage), 32'(exp_st));
            apply_idle();
        end
    endtask

    // Fault in the evaluation cycle of st followed by a one-cycle trap
    task automatic fault_at(stage_e st, mem_fault_t mf, logic ill, fault_cause_e cause);
        wait_for(st, STAGE_CYCLES - 1);
        apply_inputs(mf, ill, '0);
        sync_cycle();
        check_value("trap", 32'(trap), 32'(1'b1));
        check_value("stage", 32'(stage), 32'(stage_fetch));
        check_value("fault_num", 32'(fault_num), 32'(cause));
        check_value("control_op", 32'(control_op), 32'(ctrl_fault));
        apply_idle();
        sync_cycle();
        check_value("trap", 32'(trap), 32'(1'b0));
        apply_idle();
    endtask

    task automatic test_mem_faults();
        fault_at(stage_fetch, make_fault(1'b0, 1'b0), 1'b0, instr_addr_misaligned);
        fault_at(stage_fetch, make_fault(1'b0, 1'b1), 1'b0, instr_access_fault);
        fault_at(stage_memory, make_fault(1'b0, 1'b0), 1'b0, load_addr_misaligned);
        fault_at(stage_memory, make_fault(1'b0, 1'b1), 1'b0, load_access_fault);
        fault_at(stage_memory, make_fault(1'b1, 1'b0), 1'b0, store_addr_misaligned);
        fault_at(stage_memory, make_fault(1'b1, 1'b1), 1'b0, store_access_fault);
        wait_for(stage_decode, STAGE_CYCLES - 1);
        apply_inputs(make_fault(1'b0, 1'b1), 1'b0, '0);   // Decode never faults on memory
        sync_cycle();
        check_value("trap", 32'(trap), 32'(1'b0));
        check_value("stage", 32'(stage), 32'(stage_execute));
        check_value("fault_num", 32'(fault_num), 32'(store_access_fault));
        apply_idle();
        wait_for(stage_memory, 0);
        apply_inputs(make_fault(1'b1, 1'b1), 1'b0, '0);   // First cycle is not sampled
        sync_cycle();
        check_value("trap", 32'(trap), 32'(1'b0));
        check_value("stage", 32'(stage), 32'(stage_memory));
        apply_idle();
        sync_cycle();
        check_value("stage", 32'(stage), 32'(stage_control));
        check_value("control_op", 32'(control_op), 32'(ctrl_normal));
        check_value("fault_num", 32'(fault_num), 32'(store_access_fault));
        apply_idle();
    endtask

    task automatic test_illegal();
        fault_at(stage_decode, '0, 1'b1, cpu_ctrl_pkg::illegal_instr);
        wait_for(stage_control, STAGE_CYCLES - 1);
        apply_inputs('0, 1'b1, '0);
        sync_cycle();
        check_value("trap", 32'(trap), 32'(1'b0));
        check_value("stage", 32'(stage), 32'(stage_fetch));
        check_value("control_op", 32'(control_op), 32'(ctrl_normal));
        check_value("fault_num", 32'(fault_num), 32'(cpu_ctrl_pkg::illegal_instr));
        apply_idle();
        fault_at(stage_memory, make_fault(1'b1, 1'b1), 1'b1, cpu_ctrl_pkg::illegal_instr);
    endtask

    task automatic expect_control_op(ctrl_op_e exp);
        wait_for(stage_control, 0);
        check_value("control_op", 32'(control_op), 32'(exp));
        apply_idle();
    endtask

    task automatic next_instruction();
        wait_for(stage_fetch, 0);
        apply_idle();
    endtask

    task automatic test_interrupts();
        int_req_t req;
        req    = '0;
        req.sw = 1'b1;
        wait_for(stage_decode, 0);
        apply_inputs('0, 1'b0, req);
        expect_control_op(ctrl_sw_int);
        next_instruction();
        expect_control_op(ctrl_normal);
        req.ext = 1'b1;                          // Both strobes in one cycle
        wait_for(stage_decode, 0);
        apply_inputs('0, 1'b0, req);
        expect_control_op(ctrl_ext_int);
        next_instruction();
        expect_control_op(ctrl_sw_int);
        next_instruction();
        expect_control_op(ctrl_normal);
    endtask

    task automatic test_random();
        int          start;
        int          cycles;
        logic [31:0] roll;
        mem_fault_t  mf;
        logic        ill;
        int_req_t    req;
        start  = retired;
        cycles = 0;
        while (retired - start < RANDOM_INSTRS) begin
            sync_cycle();
            roll = $random(seed);
            mf   = '0;
            ill  = 1'b0;
            req  = '0;
            if (roll[3:0] == 4'd0) mf = make_fault(roll[4], roll[5]);
            if (roll[9:6] == 4'd1) ill = 1'b1;
            req.ext = (roll[12:10] == 3'd0);
            req.sw  = (roll[15:13] == 3'd0);
            apply_inputs(mf, ill, req);
            cycles++;
            if (cycles > 2 * RANDOM_INSTRS * INSTR_CYCLES) begin
                $display("Timeout in random run after %0d cycles", cycles);
                $display("FAIL: see errors above");
                $fatal(1);
            end
        end
        sync_cycle();
        apply_idle();
    endtask

    initial begin
        #1_000_000;                              // Overall limit on run time
        $display("Simulation did not finish in time");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    initial begin
        seed          = 66;
        retired       = 0;
        rst_n         = 1'b0;
        mem_fault     = '0;
        illegal_instr = 1'b0;
        int_req       = '0;
        test_reset();
        test_mem_faults();
        test_illegal();
        test_interrupts();
        test_random();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: project.f
hw/cpu_ctrl_pkg.sv
hw/fault_classifier.sv
hw/interrupt_latch.sv
hw/stage_sequencer.sv
hw/cpu_ctrl_top.sv
verification/cpu_ctrl_asserts.sv
verification/cpu_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the control sequencer testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD=obj_dir

rm -rf "$BUILD"
verilator --binary --timing --assert \
    --top-module cpu_ctrl_tb \
    -f project.f \
    -o cpu_ctrl_sim

"./$BUILD/cpu_ctrl_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
